/* include/cpu_cfg.svh */
// Multi-cycle core configuration
// Data, register and instruction widths shared by the package and the RTL

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath
`define CPU_DATA_W      20      // Register and ALU width

// Register file
`define CPU_NUM_REGS    8       // General registers
`define CPU_REG_ADDR_W  3       // Index into the register file

// Instruction word
`define CPU_OP_W        6       // Opcode field
`define CPU_INSTR_W     20      // Whole instruction

// Layout of the instruction word, MSB first:
//   op | src1 | src2 | dst1 | dst2 | mode | spare
// Mode and spare hold their place in the word but have no effect

`endif

/* hdl/cpu_pkg.sv */
// Multi-cycle core types
// Opcodes, sequencer states and the packed structs passed between blocks
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // Supported opcodes with their fixed encodings
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_TRAP  = 6'd0,   // Enter trap mode
        OP_NOP   = 6'd1,
        OP_NOT   = 6'd8,   // Logic group
        OP_AND   = 6'd9,
        OP_OR    = 6'd10,
        OP_XOR   = 6'd11,
        OP_SHFTR = 6'd12,  // Shift and rotate by one
        OP_SHFTL = 6'd13,
        OP_ROTR  = 6'd14,
        OP_ROTL  = 6'd15,
        OP_SWAP  = 6'd16,  // Two results
        OP_INC   = 6'd17,  // Arithmetic group
        OP_DEC   = 6'd18,
        OP_ADD   = 6'd19,
        OP_ADDC  = 6'd20,
        OP_SUB   = 6'd21,
        OP_SUBC  = 6'd22,
        OP_EQ    = 6'd23,  // Unsigned compares
        OP_GT    = 6'd24,
        OP_LT    = 6'd25,
        OP_GET   = 6'd26,
        OP_LET   = 6'd27
    } opcode_e;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITE_BACK
    } state_e;

    typedef struct packed {
        opcode_e                     op;
        logic [`CPU_REG_ADDR_W-1:0]  src1;
        logic [`CPU_REG_ADDR_W-1:0]  src2;
        logic [`CPU_REG_ADDR_W-1:0]  dst1;
        logic [`CPU_REG_ADDR_W-1:0]  dst2;
        logic                        mode;   // Unused half-word select
        // Whatever is left of the word after the named fields
        logic [`CPU_INSTR_W-`CPU_OP_W-4*`CPU_REG_ADDR_W-2:0] spare;
    } instr_t;

    typedef struct packed {
        opcode_e                 op;
        logic [`CPU_DATA_W-1:0]  a;
        logic [`CPU_DATA_W-1:0]  b;
        logic                    carry_in;   // Carry flag from the last update
    } alu_req_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0]  result1;
        logic [`CPU_DATA_W-1:0]  result2;    // Only meaningful for SWAP
        logic                    carry;
        logic                    zero;
        logic                    sign;
    } alu_rsp_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic sign;
        logic trap;    // Sticky until reset
    } status_t;

    typedef struct packed {
        logic                        we1;
        logic [`CPU_REG_ADDR_W-1:0]  addr1;
        logic [`CPU_DATA_W-1:0]      data1;
        logic                        we2;
        logic [`CPU_REG_ADDR_W-1:0]  addr2;
        logic [`CPU_DATA_W-1:0]      data2;
    } reg_wr_t;

endpackage

`default_nettype wire

/* hdl/reg_file.sv */
// General register file
// Eight entries, two combinational read ports plus a debug read port,
// and two write ports so SWAP can update both destinations in one edge
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`CPU_REG_ADDR_W-1:0]  rd_addr1,
    input  logic [`CPU_REG_ADDR_W-1:0]  rd_addr2,
    input  logic [`CPU_REG_ADDR_W-1:0]  dbg_addr,
    output logic [`CPU_DATA_W-1:0]      rd_data1,
    output logic [`CPU_DATA_W-1:0]      rd_data2,
    output logic [`CPU_DATA_W-1:0]      dbg_data,
    input  reg_wr_t                     wr
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];   // Register storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;                       // All registers start at zero
            end
        end else begin
            if (wr.we1) begin
                regs[wr.addr1] <= wr.data1;
            end
            if (wr.we2) begin
                regs[wr.addr2] <= wr.data2;          // Later assignment, wins on same address
            end
        end
    end

    // Reads see the current contents, no bypass
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
    assign dbg_data = regs[dbg_addr];   // Observation port for the outside world

    // Second port is only ever used as the companion of the first (SWAP)
    a_we2_needs_we1 : assert property (
        @(posedge clk) disable iff (reset)
        wr.we2 |-> wr.we1
    ) else $error("reg_file: write port 2 used without port 1");

endmodule

`default_nettype wire

/* hdl/alu.sv */
// Registered ALU
// Computes the result pair and the raw flags for one operation and
// captures them on the go strobe; arithmetic is unsigned modulo 2^20
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      go,
    input  alu_req_t  req,
    output alu_rsp_t  rsp
);

    localparam int W = `CPU_DATA_W;

    logic [W-1:0] a;          // Operand aliases
    logic [W-1:0] b;
    logic [W:0]   wide;       // Adder output with carry or borrow on top
    logic         is_cmp;     // Compare class, flags come from the compare itself
    alu_rsp_t     rsp_next;

    assign a = req.a;
    assign b = req.b;

    always_comb begin
        rsp_next = '0;
        wide     = '0;
        is_cmp   = 1'b0;
        case (req.op)
            OP_NOT: rsp_next.result1 = ~a;
            OP_AND: rsp_next.result1 = a & b;
            OP_OR:  rsp_next.result1 = a | b;
            OP_XOR: rsp_next.result1 = a ^ b;
            OP_SHFTR: begin
                rsp_next.result1 = {1'b0, a[W-1:1]};
                rsp_next.carry   = a[0];                  // Bit shifted out
            end
            OP_SHFTL: begin
                rsp_next.result1 = {a[W-2:0], 1'b0};
                rsp_next.carry   = a[W-1];
            end
            OP_ROTR: rsp_next.result1 = {a[0], a[W-1:1]};
            OP_ROTL: rsp_next.result1 = {a[W-2:0], a[W-1]};
            OP_SWAP: begin
                rsp_next.result1 = b;                     // dst1 gets src2
                rsp_next.result2 = a;                     // dst2 gets src1
            end
            OP_INC: begin
                wide             = {1'b0, a} + (W+1)'(1);
                rsp_next.result1 = wide[W-1:0];
                rsp_next.carry   = wide[W];               // Wrap from all ones
            end
            OP_DEC: begin
                wide             = {1'b0, a} - (W+1)'(1);
                rsp_next.result1 = wide[W-1:0];
                rsp_next.carry   = wide[W];               // Borrow, a was zero
            end
            OP_ADD, OP_ADDC: begin
                wide = {1'b0, a} + {1'b0, b};
                if (req.op == OP_ADDC) begin
                    wide = wide + (W+1)'(req.carry_in);   // Chain the prior carry
                end
                rsp_next.result1 = wide[W-1:0];
                rsp_next.carry   = wide[W];
            end
            OP_SUB, OP_SUBC: begin
                wide = {1'b0, a} - {1'b0, b};
                if (req.op == OP_SUBC) begin
                    wide = wide - (W+1)'(req.carry_in);   // Prior carry acts as borrow in
                end
                rsp_next.result1 = wide[W-1:0];
                rsp_next.carry   = wide[W];               // Top bit set on underflow
            end
            OP_EQ: begin
                is_cmp        = 1'b1;
                rsp_next.sign = (a == b);
            end
            OP_GT: begin
                is_cmp        = 1'b1;
                rsp_next.sign = (a > b);
            end
            OP_LT: begin
                is_cmp        = 1'b1;
                rsp_next.sign = (a < b);
            end
            OP_GET: begin
                is_cmp        = 1'b1;
                rsp_next.sign = (a >= b);
            end
            OP_LET: begin
                is_cmp        = 1'b1;
                rsp_next.sign = (a <= b);
            end
            default: ;                                    // NOP, TRAP, unknown
        endcase

        // Compares report equality on zero; everything else describes result1
        if (is_cmp) begin
            rsp_next.zero = (a == b);
        end else begin
            rsp_next.zero = (rsp_next.result1 == '0);
            rsp_next.sign = rsp_next.result1[W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '0;
        end else if (go) begin
            rsp <= rsp_next;          // Held through write-back
        end
    end

endmodule

`default_nettype wire

/* hdl/status_reg.sv */
// Status register
// Carry, zero and sign are taken from the ALU by operation class;
// the trap flag is set by TRAP and holds until reset
`timescale 1ns/1ps
`default_nettype none

module status_reg
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      update,
    input  opcode_e   op,
    input  alu_rsp_t  flags,
    output status_t   status
);

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (update) begin
            case (op)
                OP_TRAP: status.trap <= 1'b1;
                OP_SHFTR, OP_SHFTL, OP_INC, OP_DEC,
                OP_ADD, OP_ADDC, OP_SUB, OP_SUBC: begin
                    status.carry <= flags.carry;     // Full flag update
                    status.zero  <= flags.zero;
                    status.sign  <= flags.sign;
                end
                OP_NOT, OP_AND, OP_OR, OP_XOR, OP_ROTR, OP_ROTL: begin
                    status.zero  <= flags.zero;      // Carry untouched
                    status.sign  <= flags.sign;
                end
                OP_EQ: status.zero <= flags.zero;    // Equality only
                OP_GT, OP_LT, OP_GET, OP_LET: begin
                    status.zero  <= flags.zero;      // Operands equal
                    status.sign  <= flags.sign;      // Compare outcome
                end
                default: ;                           // SWAP, NOP, unknown
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/control_fsm.sv */
// Instruction sequencer
// Accepts one instruction at a time and walks it through fetch, decode,
// execute and write-back; drives the register file, ALU and status updates
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module control_fsm
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  instr_t                      instr,
    output logic                        instr_ready,
    output logic                        retire,
    output logic [`CPU_REG_ADDR_W-1:0]  rd_addr1,
    output logic [`CPU_REG_ADDR_W-1:0]  rd_addr2,
    input  logic [`CPU_DATA_W-1:0]      rd_data1,
    input  logic [`CPU_DATA_W-1:0]      rd_data2,
    output logic                        alu_go,
    output alu_req_t                    alu_req,
    input  alu_rsp_t                    alu_rsp,
    output reg_wr_t                     wr,
    output logic                        st_update,
    output opcode_e                     st_op,
    input  status_t                     status
);

    state_e                  state;
    instr_t                  instr_q;     // Instruction in flight
    logic [`CPU_DATA_W-1:0]  op_a;        // Operands captured in decode
    logic [`CPU_DATA_W-1:0]  op_b;
    logic                    accept;
    logic                    has_dst1;    // Operation writes a result
    logic                    has_dst2;    // Second result, SWAP only
    logic                    wb_live;     // Write-back with effects allowed

    assign instr_ready = (state == FETCH);
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:      if (instr_valid) state <= DECODE;   // Wait for the source
                DECODE:     state <= EXECUTE;
                EXECUTE:    state <= WRITE_BACK;
                WRITE_BACK: state <= FETCH;
                default:    state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
        if (state == DECODE) begin
            op_a <= rd_data1;
            op_b <= rd_data2;
        end
    end

    // Register reads follow the latched instruction
    assign rd_addr1 = instr_q.src1;
    assign rd_addr2 = instr_q.src2;

    assign alu_go           = (state == EXECUTE);
    assign alu_req.op       = instr_q.op;
    assign alu_req.a        = op_a;
    assign alu_req.b        = op_b;
    assign alu_req.carry_in = status.carry;   // Carry from the previous instruction

    // Which destinations the opcode writes
    always_comb begin
        has_dst1 = 1'b0;
        has_dst2 = 1'b0;
        case (instr_q.op)
            OP_NOT, OP_AND, OP_OR, OP_XOR,
            OP_SHFTR, OP_SHFTL, OP_ROTR, OP_ROTL,
            OP_INC, OP_DEC, OP_ADD, OP_ADDC, OP_SUB, OP_SUBC: has_dst1 = 1'b1;
            OP_SWAP: begin
                has_dst1 = 1'b1;
                has_dst2 = 1'b1;
            end
            default: ;                        // Compares, NOP, TRAP, unknown
        endcase
    end

    // Once trapped, instructions still retire but leave no trace
    assign wb_live = (state == WRITE_BACK) && !status.trap;

    assign wr.we1   = wb_live && has_dst1;
    assign wr.addr1 = instr_q.dst1;
    assign wr.data1 = alu_rsp.result1;
    assign wr.we2   = wb_live && has_dst2;
    assign wr.addr2 = instr_q.dst2;
    assign wr.data2 = alu_rsp.result2;

    assign st_update = wb_live;
    assign st_op     = instr_q.op;
    assign retire    = (state == WRITE_BACK);

    // Retire lands in write-back three cycles after the handshake
    a_retire_latency : assert property (
        @(posedge clk) disable iff (reset)
        accept |-> ##3 (retire && state == WRITE_BACK)
    ) else $error("control_fsm: retire not three cycles after accept");

endmodule

`default_nettype wire

/* hdl/cpu_core.sv */
// Multi-cycle processor core
// Sequencer, register file, ALU and status register joined together;
// instructions enter on a valid/ready port, one in flight at a time
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  instr_t                      instr,
    output logic                        instr_ready,
    output logic                        retire,
    output status_t                     status,
    input  logic [`CPU_REG_ADDR_W-1:0]  dbg_addr,
    output logic [`CPU_DATA_W-1:0]      dbg_data
);

    logic [`CPU_REG_ADDR_W-1:0]  rd_addr1;
    logic [`CPU_REG_ADDR_W-1:0]  rd_addr2;
    logic [`CPU_DATA_W-1:0]      rd_data1;
    logic [`CPU_DATA_W-1:0]      rd_data2;
    logic                        alu_go;
    alu_req_t                    alu_req;
    alu_rsp_t                    alu_rsp;
    reg_wr_t                     reg_wr;
    logic                        st_update;
    opcode_e                     st_op;

    control_fsm ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .retire      (retire),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .alu_go      (alu_go),
        .alu_req     (alu_req),
        .alu_rsp     (alu_rsp),
        .wr          (reg_wr),
        .st_update   (st_update),
        .st_op       (st_op),
        .status      (status)
    );

    reg_file regs_i (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .dbg_addr (dbg_addr),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .dbg_data (dbg_data),
        .wr       (reg_wr)
    );

    alu alu_i (
        .clk   (clk),
        .reset (reset),
        .go    (alu_go),
        .req   (alu_req),
        .rsp   (alu_rsp)
    );

    status_reg status_i (
        .clk    (clk),
        .reset  (reset),
        .update (st_update),
        .op     (st_op),
        .flags  (alu_rsp),
        .status (status)
    );

endmodule

`default_nettype wire

/* tb/tb_cpu_core.sv */
// Testbench for the multi-cycle processor core
// Loads registers with INC and shift sequences, then runs LFSR driven
// operations against a reference model; concurrent assertions compare
// handshake timing, register contents and status flags
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_core
    import cpu_pkg::*;
();

    localparam int W          = `CPU_DATA_W;
    localparam int LOAD_BITS  = 12;    // Random bits shifted into each loaded register
    localparam int N_LOAD     = 6 * (2 * LOAD_BITS + 1) + 1;
    localparam int N_DIRECTED = 10;
    localparam int N_RAND     = 120;
    localparam int N_TRAPPED  = 12;    // Random ops issued after TRAP
    localparam int N_INSTR    = N_LOAD + N_DIRECTED + N_RAND + 2 + N_TRAPPED;

    logic                        clk;
    logic                        reset;
    logic                        instr_valid;
    instr_t                      instr;
    logic                        instr_ready;
    logic                        retire;
    status_t                     status;
    logic [`CPU_REG_ADDR_W-1:0]  dbg_addr;
    logic [`CPU_DATA_W-1:0]      dbg_data;

    logic [W-1:0]                m_regs [`CPU_NUM_REGS];   // Reference register file
    status_t                     m_status;                 // Reference flags
    logic [31:0]                 lfsr_state = 32'h8c2c4ad4;
    logic [`CPU_REG_ADDR_W-1:0]  p_addr1;                  // Registers to look at after retire
    logic [`CPU_REG_ADDR_W-1:0]  p_addr2;
    logic [W-1:0]                exp_data;
    status_t                     exp_status;
    logic                        chk;                      // Compare window for dbg_data and status
    event                        check_ev;

    cpu_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .retire      (retire),
        .status      (status),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                 // 4 ns period
    end

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic instr_t make_instr(opcode_e op, logic [2:0] s1, logic [2:0] s2,
                                          logic [2:0] d1, logic [2:0] d2);
        instr_t ins;
        ins      = '0;                         // Mode and spare left at zero
        ins.op   = op;
        ins.src1 = s1;
        ins.src2 = s2;
        ins.dst1 = d1;
        ins.dst2 = d2;
        return ins;
    endfunction

    function automatic instr_t rand_instr();
        instr_t      ins;
        logic [31:0] v;
        v      = take_bits(5);
        ins.op = (v[4:0] == 5'd0) ? OP_ADDC : opcode_e'({1'b0, v[4:0]});   // No TRAP here
        v        = take_bits(12);
        ins.src1 = v[11:9];
        ins.src2 = v[8:6];
        ins.dst1 = v[5:3];
        ins.dst2 = v[2:0];
        v         = take_bits(2);
        ins.mode  = v[1];                      // Ignored by the core
        ins.spare = v[0:0];
        return ins;
    endfunction

    // Reference model, applied once per retired instruction
    task automatic model_retire(instr_t ins);
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] r;
        logic [W:0]   sum;
        logic         ci;
        logic         c;
        a   = m_regs[ins.src1];
        b   = m_regs[ins.src2];
        ci  = (ins.op == OP_ADDC || ins.op == OP_SUBC) ? m_status.carry : 1'b0;
        sum = {1'b0, a} + {1'b0, b} + (W+1)'(ci);
        case (ins.op)
            OP_NOT:          r = ~a;
            OP_AND:          r = a & b;
            OP_OR:           r = a | b;
            OP_XOR:          r = a ^ b;
            OP_SHFTR:        r = a >> 1;
            OP_SHFTL:        r = a << 1;
            OP_ROTR:         r = {a[0], a[W-1:1]};
            OP_ROTL:         r = {a[W-2:0], a[W-1]};
            OP_INC:          r = a + W'(1);
            OP_DEC:          r = a - W'(1);
            OP_ADD, OP_ADDC: r = a + b + W'(ci);
            OP_SUB, OP_SUBC: r = a - b - W'(ci);
            default:         r = '0;
        endcase
        case (ins.op)                          // Carry, or the compare outcome
            OP_SHFTR:        c = a[0];
            OP_SHFTL:        c = a[W-1];
            OP_INC:          c = (a == {W{1'b1}});
            OP_DEC:          c = (a == '0);
            OP_ADD, OP_ADDC: c = sum[W];
            OP_SUB, OP_SUBC: c = ({1'b0, a} < ({1'b0, b} + (W+1)'(ci)));
            OP_GT:           c = (a > b);
            OP_LT:           c = (a < b);
            OP_GET:          c = (a >= b);
            OP_LET:          c = (a <= b);
            default:         c = 1'b0;
        endcase
        if (!m_status.trap) begin
            case (ins.op)
                OP_TRAP: m_status.trap = 1'b1;
                OP_SWAP: begin
                    m_regs[ins.dst1] = b;
                    m_regs[ins.dst2] = a;      // Second write wins on a shared address
                end
                OP_EQ: m_status.zero = (a == b);
                OP_GT, OP_LT, OP_GET, OP_LET: begin
                    m_status.zero = (a == b);
                    m_status.sign = c;
                end
                OP_NOT, OP_AND, OP_OR, OP_XOR, OP_ROTR, OP_ROTL: begin
                    m_regs[ins.dst1] = r;
                    m_status.zero    = (r == '0);
                    m_status.sign    = r[W-1];
                end
                OP_SHFTR, OP_SHFTL, OP_INC, OP_DEC,
                OP_ADD, OP_ADDC, OP_SUB, OP_SUBC: begin
                    m_regs[ins.dst1] = r;
                    m_status.carry   = c;
                    m_status.zero    = (r == '0);
                    m_status.sign    = r[W-1];
                end
                default: ;                     // NOP and unknown opcodes
            endcase
        end
    endtask

    // Called 1 ns after an edge; returns 1 ns after the write-back edge
    task automatic issue(instr_t ins);
        instr       = ins;
        instr_valid = 1'b1;
        while (!instr_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);                        // Handshake edge
        #1;
        instr_valid = 1'b0;
        while (!retire) begin
            @(posedge clk);
            #1;
        end
        model_retire(ins);
        p_addr1 = ins.dst1;
        p_addr2 = (ins.op == OP_SWAP) ? ins.dst2 : ins.src1;   // Source must stay intact
        -> check_ev;
        @(posedge clk);
        #1;
    endtask

    // Two compare cycles per retire, overlapping the next handshake
    initial begin
        forever begin
            @(check_ev);
            @(posedge clk);
            #1;
            dbg_addr   = p_addr1;
            exp_data   = m_regs[p_addr1];
            exp_status = m_status;
            chk        = 1'b1;
            @(posedge clk);
            #1;
            dbg_addr = p_addr2;
            exp_data = m_regs[p_addr2];
            @(posedge clk);
            #1;
            chk = 1'b0;
        end
    end

    a_reset_idle : assert property (
        @(posedge clk) $fell(reset) |-> instr_ready && !retire && status == '0
    ) else stop_on_error($sformatf("FAILED at %0t ns: core not idle after reset", $time));

    a_handshake : assert property (
        @(posedge clk) disable iff (reset)
        (instr_valid && instr_ready) |=> (!retire && !instr_ready) ##1
            (!retire && !instr_ready) ##1 (retire && !instr_ready) ##1 (instr_ready && !retire)
    ) else stop_on_error($sformatf("FAILED at %0t ns: retire or ready timing wrong", $time));

    a_reg_value : assert property (
        @(posedge clk) disable iff (reset) chk |-> dbg_data == exp_data
    ) else stop_on_error($sformatf("FAILED at %0t ns: r%0d is %h, expected %h",
                                   $time, dbg_addr, dbg_data, exp_data));

    a_flags : assert property (
        @(posedge clk) disable iff (reset) chk |-> status == exp_status
    ) else stop_on_error($sformatf("FAILED at %0t ns: status %b, expected %b (c z s t)",
                                   $time, status, exp_status));

    initial begin
        repeat (N_INSTR * 6 + 50) @(posedge clk);
        stop_on_error($sformatf("Timeout: the run did not end within %0d cycles",
                                N_INSTR * 6 + 50));
    end

    initial begin
        logic [31:0] v;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        exp_data    = '0;
        exp_status  = '0;
        chk         = 1'b0;
        m_status    = '0;
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Build r0..r5 bit by bit, then rotate the low bit to the top
        for (int k = 0; k < 6; k++) begin
            v = take_bits(LOAD_BITS);
            for (int i = LOAD_BITS - 1; i >= 0; i--) begin
                issue(make_instr(OP_SHFTL, 3'(k), 3'(k), 3'(k), 3'd0));
                if (v[i]) begin
                    issue(make_instr(OP_INC, 3'(k), 3'(k), 3'(k), 3'd0));
                end
            end
            issue(make_instr(OP_ROTR, 3'(k), 3'(k), 3'(k), 3'd0));
        end
        issue(make_instr(OP_DEC, 3'd7, 3'd7, 3'd7, 3'd0));     // r7 wraps to all ones

        issue(make_instr(OP_SWAP, 3'd1, 3'd2, 3'd3, 3'd4));
        issue(make_instr(OP_ADD, 3'd7, 3'd7, 3'd6, 3'd0));     // Sets carry
        issue(make_instr(OP_ADDC, 3'd0, 3'd1, 3'd5, 3'd0));
        issue(make_instr(OP_SUB, 3'd0, 3'd7, 3'd2, 3'd0));     // Borrow
        issue(make_instr(OP_SUBC, 3'd3, 3'd4, 3'd1, 3'd0));
        issue(make_instr(OP_EQ, 3'd7, 3'd7, 3'd0, 3'd0));
        issue(make_instr(OP_GT, 3'd0, 3'd1, 3'd2, 3'd0));
        issue(make_instr(OP_LET, 3'd2, 3'd2, 3'd3, 3'd0));
        issue(make_instr(OP_NOP, 3'd1, 3'd2, 3'd4, 3'd5));
        issue(make_instr(opcode_e'(6'd45), 3'd3, 3'd4, 3'd5, 3'd6));

        for (int n = 0; n < N_RAND; n++) begin
            issue(rand_instr());
        end

        // After TRAP, instructions retire with no effect
        issue(make_instr(OP_TRAP, 3'd0, 3'd0, 3'd0, 3'd0));
        issue(make_instr(OP_INC, 3'd0, 3'd0, 3'd0, 3'd0));
        for (int n = 0; n < N_TRAPPED; n++) begin
            issue(rand_instr());
        end

        repeat (4) @(posedge clk);             // Let the last compare window close
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/status_reg.sv
hdl/control_fsm.sv
hdl/cpu_core.sv
tb/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
# Compile and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu_core \
    -Mdir "$BUILD" -o tb_cpu_core -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/tb_cpu_core" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
